/* flist.f */
+incdir+common
common/ppu_pkg.sv
design/n64_vdemux.sv
design/n64_vinfo.sv
postproc/gamma_correct.sv
postproc/scanline_emu.sv
design/ppu_top.sv
dv/tb_ppu.sv

/* run.sh */
#!/bin/sh
# Build and run the ppu testbench with Verilator, then judge the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_ppu \
    -Mdir "$BUILD_DIR"; then
  echo "verilator build failed"
  exit 1
fi

"$BUILD_DIR/Vtb_ppu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -q "Test completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

/* dv/tb_ppu.sv */
// testbench for the n64 pixel front end with reference model, scoreboard and watchdog
`timescale 1ns/1ps
`include "ppu_defines.svh"

module tb_ppu;

  localparam int LINE_PIXELS = 8;
  localparam int SHORT_LINES = 4;
  localparam int PIPE_DEPTH  = 3;
  localparam int TOTAL_PIXELS = (7 * SHORT_LINES + 3 * 263 + 312 + 313 + 312) * LINE_PIXELS;
  // four bus cycles per pixel at 20 ns and a margin for resets and drains
  localparam int WATCHDOG_NS = TOTAL_PIXELS * 4 * 20 + 20000;

  logic                n64_clk;
  logic                arst_n;
  logic                nvdsync;
  ppu_pkg::color_in_t  vd_in;
  logic                cfg_16bit;
  ppu_pkg::gamma_e     cfg_gamma;
  logic                cfg_sl_en;
  ppu_pkg::sl_str_t    cfg_sl_str;
  ppu_pkg::pixel_out_t vd_out;
  logic                valid;
  logic                hsync;
  logic                vsync;
  logic                de;
  logic                vdata_detected;
  logic                pal;
  logic                interlaced;
  logic [31:0]         lfsr_q;
  // {HSYNC, VSYNC, DE, pixel}
  logic [26:0]         exp_q[$];

  ppu_top dut_i (
    .N64_CLK_i        (n64_clk),
    .arst_n_i         (arst_n),
    .nVDSYNC_i        (nvdsync),
    .VD_i             (vd_in),
    .cfg_16bit_i      (cfg_16bit),
    .cfg_gamma_i      (cfg_gamma),
    .cfg_sl_en_i      (cfg_sl_en),
    .cfg_sl_str_i     (cfg_sl_str),
    .VD_o             (vd_out),
    .valid_o          (valid),
    .HSYNC_o          (hsync),
    .VSYNC_o          (vsync),
    .DE_o             (de),
    .vdata_detected_o (vdata_detected),
    .pal_o            (pal),
    .interlaced_o     (interlaced)
  );

  always #10 n64_clk = ~n64_clk;

  // ==========================================================================
  // random colours and reference model
  // ==========================================================================

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end else begin
      return s >> 1;
    end
  endfunction

  // one lfsr step per colour bit
  function automatic ppu_pkg::color_in_t rand_color();
    ppu_pkg::color_in_t v;
    v = '0;
    for (int i = 0; i < `PPU_COLOR_W_IN; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[`PPU_COLOR_W_IN-2:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic int exp_channel(input int c7, input logic mode16,
                                     input ppu_pkg::gamma_e g, input logic dim, input int s);
    int m;
    int e;
    int r;
    m = mode16 ? (c7 / 4) * 4 : c7;
    // msb appended below the 7 bits
    e = m * 2 + m / 64;
    case (g)
      ppu_pkg::GAMMA_BRIGHT: r = e + (255 - e) / 4;
      ppu_pkg::GAMMA_DARK:   r = e - e / 4;
      default:               r = e;
    endcase
    if (dim) begin
      r = r - (r * ((s + 1) * 16 - 1)) / 256;
    end
    return r;
  endfunction

  function automatic ppu_pkg::pixel_out_t ref_pixel(input ppu_pkg::color_in_t r,
                                                    input ppu_pkg::color_in_t g,
                                                    input ppu_pkg::color_in_t b,
                                                    input logic odd);
    logic dim;
    dim = cfg_sl_en && odd;
    return {8'(exp_channel(r, cfg_16bit, cfg_gamma, dim, cfg_sl_str)),
            8'(exp_channel(g, cfg_16bit, cfg_gamma, dim, cfg_sl_str)),
            8'(exp_channel(b, cfg_16bit, cfg_gamma, dim, cfg_sl_str))};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_flags(input logic exp_vd, input logic exp_pal, input logic exp_il);
    check_value("vdata_detected_o", vdata_detected, exp_vd);
    check_value("pal_o", pal, exp_pal);
    check_value("interlaced_o", interlaced, exp_il);
  endtask

  // ==========================================================================
  // stimulus
  // ==========================================================================

  task automatic apply_reset();
    @(posedge n64_clk);
    arst_n <= 1'b0;
    repeat (8) @(posedge n64_clk);
    arst_n <= 1'b1;
    @(posedge n64_clk);
  endtask

  // idle cycles until the pipeline is empty
  task automatic drain();
    repeat (PIPE_DEPTH + 2) @(posedge n64_clk);
  endtask

  task automatic set_config(input logic m16, input ppu_pkg::gamma_e g, input logic en,
                            input ppu_pkg::sl_str_t s);
    drain();
    @(posedge n64_clk);
    cfg_16bit  <= m16;
    cfg_gamma  <= g;
    cfg_sl_en  <= en;
    cfg_sl_str <= s;
  endtask

  task automatic send_pixel(input ppu_pkg::sync_t nib, input logic odd);
    ppu_pkg::color_in_t r;
    ppu_pkg::color_in_t g;
    ppu_pkg::color_in_t b;
    r = rand_color();
    g = rand_color();
    b = rand_color();
    @(posedge n64_clk);
    // config written on an earlier edge is settled here
    exp_q.push_back({!nib[`PPU_SYNC_NHSYNC], !nib[`PPU_SYNC_NVSYNC],
                     !nib[`PPU_SYNC_NCLAMP], ref_pixel(r, g, b, odd)});
    nvdsync <= 1'b0;
    vd_in   <= {3'b000, nib};
    @(posedge n64_clk);
    nvdsync <= 1'b1;
    vd_in   <= r;
    @(posedge n64_clk);
    vd_in   <= g;
    @(posedge n64_clk);
    vd_in   <= b;
  endtask

  task automatic send_frame(input int lines);
    ppu_pkg::sync_t nib;
    for (int line = 0; line < lines; line++) begin
      for (int px = 0; px < LINE_PIXELS; px++) begin
        nib[`PPU_SYNC_NVSYNC] = (line != 0);
        nib[`PPU_SYNC_NCLAMP] = !(px >= 1 && px <= LINE_PIXELS - 2);
        nib[`PPU_SYNC_NHSYNC] = (px != 0);
        nib[`PPU_SYNC_NCSYNC] = nib[`PPU_SYNC_NVSYNC] && nib[`PPU_SYNC_NHSYNC];
        send_pixel(nib, (line % 2) == 1);
      end
    end
  endtask

  // ==========================================================================
  // scoreboard
  // ==========================================================================

  always @(posedge n64_clk) begin
    logic [26:0] exp_w;
    if (valid) begin
      if (exp_q.size() == 0) begin
        $display("output pixel at %0d ns arrived with no expected pixel pending", $time);
        $display("Test failed");
        $fatal(1);
      end else begin
        exp_w = exp_q.pop_front();
        check_value("VD_o", vd_out, exp_w[23:0]);
        check_value("HSYNC_o", hsync, exp_w[26]);
        check_value("VSYNC_o", vsync, exp_w[25]);
        check_value("DE_o", de, exp_w[24]);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("simulation timed out before all tests finished");
    $display("Test failed");
    $fatal(1);
  end

  initial begin
    n64_clk    = 1'b0;
    arst_n     = 1'b0;
    nvdsync    = 1'b1;
    vd_in      = '0;
    cfg_16bit  = 1'b0;
    cfg_gamma  = ppu_pkg::GAMMA_LINEAR;
    cfg_sl_en  = 1'b0;
    cfg_sl_str = '0;
    lfsr_q     = 32'h9534;
    apply_reset();
    check_value("valid_o", valid, 1'b0);
    check_value("VD_o", vd_out, '0);
    check_value("HSYNC_o", hsync, 1'b0);
    check_value("VSYNC_o", vsync, 1'b0);
    check_value("DE_o", de, 1'b0);
    check_flags(1'b0, 1'b0, 1'b0);

    // colour path over short frames
    send_frame(SHORT_LINES);
    set_config(1'b1, ppu_pkg::GAMMA_LINEAR, 1'b0, 4'd0);
    send_frame(SHORT_LINES);
    set_config(1'b0, ppu_pkg::GAMMA_BRIGHT, 1'b0, 4'd0);
    send_frame(SHORT_LINES);
    set_config(1'b0, ppu_pkg::GAMMA_DARK, 1'b0, 4'd0);
    send_frame(SHORT_LINES);
    set_config(1'b0, ppu_pkg::GAMMA_LINEAR, 1'b1, 4'd0);
    send_frame(SHORT_LINES);
    set_config(1'b0, ppu_pkg::GAMMA_LINEAR, 1'b1, 4'd7);
    send_frame(SHORT_LINES);
    set_config(1'b0, ppu_pkg::GAMMA_LINEAR, 1'b1, 4'd15);
    send_frame(SHORT_LINES);

    // ntsc progressive
    set_config(1'b0, ppu_pkg::GAMMA_LINEAR, 1'b0, 4'd0);
    apply_reset();
    repeat (3) send_frame(263);
    check_flags(1'b1, 1'b0, 1'b0);

    // pal interlaced
    drain();
    apply_reset();
    send_frame(312);
    // no flag before the second frame start
    check_flags(1'b0, 1'b0, 1'b0);
    send_frame(313);
    check_flags(1'b1, 1'b1, 1'b0);
    send_frame(312);
    check_flags(1'b1, 1'b1, 1'b1);

    drain();
    if (exp_q.size() == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("%0d expected pixels never came out of the DUT", exp_q.size());
      $display("Test failed");
      $fatal(1);
    end
  end

endmodule

/* design/ppu_top.sv */
// n64 pixel processing front end: bus demux, video info and post-processing chain
`timescale 1ns/1ps

module ppu_top (
  input  logic                N64_CLK_i,
  input  logic                arst_n_i,
  input  logic                nVDSYNC_i,
  input  ppu_pkg::color_in_t  VD_i,
  input  logic                cfg_16bit_i,
  input  ppu_pkg::gamma_e     cfg_gamma_i,
  input  logic                cfg_sl_en_i,
  input  ppu_pkg::sl_str_t    cfg_sl_str_i,
  output ppu_pkg::pixel_out_t VD_o,
  output logic                valid_o,
  output logic                HSYNC_o,
  output logic                VSYNC_o,
  output logic                DE_o,
  output logic                vdata_detected_o,
  output logic                pal_o,
  output logic                interlaced_o
);

  ppu_pkg::sync_t      dmx_sync_w;
  ppu_pkg::pixel_in_t  dmx_pix_w;
  logic                dmx_valid_w;
  ppu_pkg::sync_t      gc_sync_w;
  ppu_pkg::pixel_out_t gc_pix_w;
  logic                gc_valid_w;

  // ==========================================================================
  // front end
  // ==========================================================================

  n64_vdemux vdemux_i (
    .N64_CLK_i   (N64_CLK_i),
    .arst_n_i    (arst_n_i),
    .nVDSYNC_i   (nVDSYNC_i),
    .VD_i        (VD_i),
    .sync_o      (dmx_sync_w),
    .pix_o       (dmx_pix_w),
    .pix_valid_o (dmx_valid_w)
  );

  n64_vinfo vinfo_i (
    .N64_CLK_i        (N64_CLK_i),
    .arst_n_i         (arst_n_i),
    .sync_i           (dmx_sync_w),
    .pix_valid_i      (dmx_valid_w),
    .vdata_detected_o (vdata_detected_o),
    .pal_o            (pal_o),
    .interlaced_o     (interlaced_o)
  );

  // ==========================================================================
  // post-processing
  // ==========================================================================

  gamma_correct gamma_i (
    .N64_CLK_i   (N64_CLK_i),
    .arst_n_i    (arst_n_i),
    .pix_i       (dmx_pix_w),
    .sync_i      (dmx_sync_w),
    .pix_valid_i (dmx_valid_w),
    .cfg_16bit_i (cfg_16bit_i),
    .cfg_gamma_i (cfg_gamma_i),
    .pix_o       (gc_pix_w),
    .sync_o      (gc_sync_w),
    .pix_valid_o (gc_valid_w)
  );

  // last stage drives the video outputs
  scanline_emu scanline_i (
    .N64_CLK_i   (N64_CLK_i),
    .arst_n_i    (arst_n_i),
    .pix_i       (gc_pix_w),
    .sync_i      (gc_sync_w),
    .pix_valid_i (gc_valid_w),
    .sl_en_i     (cfg_sl_en_i),
    .sl_str_i    (cfg_sl_str_i),
    .VD_o        (VD_o),
    .valid_o     (valid_o),
    .HSYNC_o     (HSYNC_o),
    .VSYNC_o     (VSYNC_o),
    .DE_o        (DE_o)
  );

endmodule

/* postproc/scanline_emu.sv */
// horizontal scanline emulation that darkens every odd line by a set strength
`timescale 1ns/1ps
`include "ppu_defines.svh"

module scanline_emu (
  input  logic                N64_CLK_i,
  input  logic                arst_n_i,
  input  ppu_pkg::pixel_out_t pix_i,
  input  ppu_pkg::sync_t      sync_i,
  input  logic                pix_valid_i,
  input  logic                sl_en_i,
  input  ppu_pkg::sl_str_t    sl_str_i,
  output ppu_pkg::pixel_out_t VD_o,
  output logic                valid_o,
  output logic                HSYNC_o,
  output logic                VSYNC_o,
  output logic                DE_o
);

  localparam int unsigned W = `PPU_COLOR_W_OUT;

  ppu_pkg::sync_t      sync_prev_q;
  logic                parity_q;
  logic                parity_w;
  logic                dim_w;
  logic [`PPU_SL_STR_W:0] str_inc_w;
  logic [8:0]          s8_full_w;
  ppu_pkg::color_out_t s8_w;

  function automatic ppu_pkg::color_out_t dim_color(
    input ppu_pkg::color_out_t c,
    input ppu_pkg::color_out_t s
  );
    logic [15:0] prod;
    prod = c * s;
    return c - prod[15:8];
  endfunction

  // strength 0..15 maps to 15..255
  assign str_inc_w = {1'b0, sl_str_i} + 1'b1;
  assign s8_full_w = {str_inc_w, 4'b0000} - 9'd1;
  assign s8_w      = s8_full_w[7:0];

  // new parity already applies to the pixel that opens a line
  always_comb begin
    parity_w = parity_q;
    if (pix_valid_i && sync_prev_q[`PPU_SYNC_NVSYNC] && !sync_i[`PPU_SYNC_NVSYNC]) begin
      parity_w = 1'b0;
    end else if (pix_valid_i && sync_prev_q[`PPU_SYNC_NHSYNC] &&
                 !sync_i[`PPU_SYNC_NHSYNC]) begin
      parity_w = !parity_q;
    end
  end

  assign dim_w = sl_en_i && parity_w;

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_prev_q <= '1;
      parity_q    <= 1'b0;
      valid_o     <= 1'b0;
      VD_o        <= '0;
      HSYNC_o     <= 1'b0;
      VSYNC_o     <= 1'b0;
      DE_o        <= 1'b0;
    end else begin
      valid_o <= pix_valid_i;
      if (pix_valid_i) begin
        sync_prev_q <= sync_i;
        parity_q    <= parity_w;
        VD_o        <= dim_w ? {dim_color(pix_i[2*W +: W], s8_w),
                                dim_color(pix_i[W +: W], s8_w),
                                dim_color(pix_i[0 +: W], s8_w)} : pix_i;
        // active high at the output
        HSYNC_o <= !sync_i[`PPU_SYNC_NHSYNC];
        VSYNC_o <= !sync_i[`PPU_SYNC_NVSYNC];
        DE_o    <= !sync_i[`PPU_SYNC_NCLAMP];
      end
    end
  end

endmodule

/* postproc/gamma_correct.sv */
// colour depth reduction, expansion to 8 bits and gamma curve per channel
`timescale 1ns/1ps
`include "ppu_defines.svh"

module gamma_correct (
  input  logic                N64_CLK_i,
  input  logic                arst_n_i,
  input  ppu_pkg::pixel_in_t  pix_i,
  input  ppu_pkg::sync_t      sync_i,
  input  logic                pix_valid_i,
  input  logic                cfg_16bit_i,
  input  ppu_pkg::gamma_e     cfg_gamma_i,
  output ppu_pkg::pixel_out_t pix_o,
  output ppu_pkg::sync_t      sync_o,
  output logic                pix_valid_o
);

  localparam int unsigned W = `PPU_COLOR_W_IN;

  function automatic ppu_pkg::color_out_t conv_color(
    input ppu_pkg::color_in_t c,
    input logic               mode16,
    input ppu_pkg::gamma_e    curve
  );
    ppu_pkg::color_in_t  m;
    ppu_pkg::color_out_t e;
    m = c;
    // 16-bit mode drops the two lsbs
    if (mode16) begin
      m[1:0] = 2'b00;
    end
    e = {m, m[W-1]};
    case (curve)
      ppu_pkg::GAMMA_BRIGHT: return e + ((8'hFF - e) >> 2);
      ppu_pkg::GAMMA_DARK:   return e - (e >> 2);
      default:               return e;
    endcase
  endfunction

  always_ff @(posedge N64_CLK_i) begin
    if (pix_valid_i) begin
      pix_o  <= {conv_color(pix_i[2*W +: W], cfg_16bit_i, cfg_gamma_i),
                 conv_color(pix_i[W +: W], cfg_16bit_i, cfg_gamma_i),
                 conv_color(pix_i[0 +: W], cfg_16bit_i, cfg_gamma_i)};
      sync_o <= sync_i;
    end
  end

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= pix_valid_i;
    end
  end

endmodule

/* design/n64_vinfo.sv */
// video info detection from the sync stream: data present, PAL and interlacing
`timescale 1ns/1ps
`include "ppu_defines.svh"

module n64_vinfo (
  input  logic           N64_CLK_i,
  input  logic           arst_n_i,
  input  ppu_pkg::sync_t sync_i,
  input  logic           pix_valid_i,
  output logic           vdata_detected_o,
  output logic           pal_o,
  output logic           interlaced_o
);

  ppu_pkg::sync_t    sync_prev_q;
  ppu_pkg::linecnt_t line_cnt_q;
  ppu_pkg::linecnt_t prev_cnt_q;
  logic [1:0]        frames_seen_q;
  logic              hs_fall_w;
  logic              vs_fall_w;

  // edges against the previous pixel's nibble
  assign hs_fall_w = pix_valid_i && sync_prev_q[`PPU_SYNC_NHSYNC] &&
                     !sync_i[`PPU_SYNC_NHSYNC];
  assign vs_fall_w = pix_valid_i && sync_prev_q[`PPU_SYNC_NVSYNC] &&
                     !sync_i[`PPU_SYNC_NVSYNC];

  // idle level of all syncs is high
  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_prev_q <= '1;
    end else if (pix_valid_i) begin
      sync_prev_q <= sync_i;
    end
  end

  // ==========================================================================
  // line counting
  // ==========================================================================

  // frame start pixel usually also opens line 0, so it counts as one
  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      line_cnt_q <= '0;
    end else if (vs_fall_w) begin
      line_cnt_q <= {{(`PPU_LINECNT_W-1){1'b0}}, hs_fall_w};
    end else if (hs_fall_w) begin
      line_cnt_q <= line_cnt_q + 1'b1;
    end
  end

  // ==========================================================================
  // flags, updated on frame starts only
  // ==========================================================================

  // first frame start closes a partial frame, nothing is judged there
  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      frames_seen_q    <= 2'd0;
      prev_cnt_q       <= '0;
      vdata_detected_o <= 1'b0;
      pal_o            <= 1'b0;
      interlaced_o     <= 1'b0;
    end else if (vs_fall_w) begin
      prev_cnt_q <= line_cnt_q;
      if (frames_seen_q != 2'd2) begin
        frames_seen_q <= frames_seen_q + 2'd1;
      end
      if (frames_seen_q != 2'd0) begin
        vdata_detected_o <= 1'b1;
        pal_o            <= line_cnt_q > ppu_pkg::linecnt_t'(`PPU_PAL_LINES);
      end
      // needs two complete frames to compare
      if (frames_seen_q == 2'd2) begin
        interlaced_o <= line_cnt_q != prev_cnt_q;
      end
    end
  end

endmodule

/* design/n64_vdemux.sv */
// n64 video bus demux that turns four bus cycles into one sync nibble and pixel
`timescale 1ns/1ps
`include "ppu_defines.svh"

module n64_vdemux (
  input  logic               N64_CLK_i,
  input  logic               arst_n_i,
  input  logic               nVDSYNC_i,
  input  ppu_pkg::color_in_t VD_i,
  output ppu_pkg::sync_t     sync_o,
  output ppu_pkg::pixel_in_t pix_o,
  output logic               pix_valid_o
);

  logic [1:0]         phase_q;
  ppu_pkg::sync_t     sync_hold_q;
  ppu_pkg::color_in_t red_hold_q;
  ppu_pkg::color_in_t green_hold_q;
  logic               blue_w;

  // blue is on the bus, pixel is complete at this edge
  assign blue_w = nVDSYNC_i && (phase_q == `PPU_PH_BLUE);

  // ==========================================================================
  // phase tracking
  // ==========================================================================

  // parks in idle until the next sync nibble
  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q <= `PPU_PH_IDLE;
    end else if (!nVDSYNC_i) begin
      phase_q <= `PPU_PH_RED;
    end else if (phase_q != `PPU_PH_IDLE) begin
      phase_q <= phase_q + 2'd1;
    end
  end

  // holding registers for the parts that arrive early
  always_ff @(posedge N64_CLK_i) begin
    if (!nVDSYNC_i) begin
      sync_hold_q <= VD_i[`PPU_SYNC_W-1:0];
    end else if (phase_q == `PPU_PH_RED) begin
      red_hold_q <= VD_i;
    end else if (phase_q == `PPU_PH_GREEN) begin
      green_hold_q <= VD_i;
    end
  end

  // ==========================================================================
  // pixel output
  // ==========================================================================

  always_ff @(posedge N64_CLK_i) begin
    if (blue_w) begin
      pix_o  <= {red_hold_q, green_hold_q, VD_i};
      sync_o <= sync_hold_q;
    end
  end

  // one pulse per pixel, aligned with pix_o
  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= blue_w;
    end
  end

endmodule

/* common/ppu_pkg.sv */
// pixel processing unit types shared by the front end and post-processing
`include "ppu_defines.svh"

package ppu_pkg;

  // one colour as carried on the n64 bus
  typedef logic [`PPU_COLOR_W_IN-1:0] color_in_t;

  // red, green, blue from the msb down
  typedef logic [3*`PPU_COLOR_W_IN-1:0] pixel_in_t;

  // one colour after expansion
  typedef logic [`PPU_COLOR_W_OUT-1:0] color_out_t;

  typedef logic [3*`PPU_COLOR_W_OUT-1:0] pixel_out_t;

  // sync nibble, see the bit positions in the defines
  typedef logic [`PPU_SYNC_W-1:0] sync_t;

  // lines per frame
  typedef logic [`PPU_LINECNT_W-1:0] linecnt_t;

  // gamma curve select, value 3 behaves as linear
  typedef enum logic [1:0] {
    GAMMA_LINEAR = 2'd0,
    GAMMA_BRIGHT = 2'd1,
    GAMMA_DARK   = 2'd2
  } gamma_e;

  typedef logic [`PPU_SL_STR_W-1:0] sl_str_t;

endpackage

/* common/ppu_defines.svh */
// pixel processing unit constants for bus widths, pixel phases and video thresholds
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// colour widths on the n64 bus and at the output
`define PPU_COLOR_W_IN  7
`define PPU_COLOR_W_OUT 8

// sync nibble, all bits active low
`define PPU_SYNC_W      4
`define PPU_SYNC_NVSYNC 3
`define PPU_SYNC_NCLAMP 2
`define PPU_SYNC_NHSYNC 1
`define PPU_SYNC_NCSYNC 0

// bus phase after the sync nibble cycle
`define PPU_PH_RED   2'd0
`define PPU_PH_GREEN 2'd1
`define PPU_PH_BLUE  2'd2
`define PPU_PH_IDLE  2'd3

// line counting, more lines than this means PAL
`define PPU_LINECNT_W 10
`define PPU_PAL_LINES 288

// scanline strength setting
`define PPU_SL_STR_W 4

`endif
